// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := im2col_addr_tb
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := ** FAIL **
PASS_MSG := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "test failed, run did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
src/conv_addr_pkg.sv
src/apb_cfg_decode.sv
src/window_walker.sv
src/addr_accum.sv
src/im2col_addr_top.sv
verif/im2col_addr_props.sv
verif/im2col_addr_tb.sv

// ==== src/addr_accum.sv ====
`timescale 1ns/10ps

module addr_accum #(
    parameter logic [conv_addr_pkg::ADDR_W-1:0] ADDR_BASE = '0
) (
    input  logic                               clk,
    input  logic                               rstn,
    input  conv_addr_pkg::step_t               step,
    input  logic                               step_valid,
    output logic                               step_ready,
    input  conv_addr_pkg::jump_t               jump,
    output logic [conv_addr_pkg::ADDR_W-1:0]   addr,
    output logic                               addr_valid,
    output logic                               addr_last,
    input  logic                               addr_ready,
    output logic                               last_done
);

    localparam int AW = conv_addr_pkg::ADDR_W;

    // offsets from ADDR_BASE
    logic [AW-1:0] cur_addr;
    logic [AW-1:0] win_base;
    logic [AW-1:0] row_base;
    logic [AW-1:0] cur_nx;
    logic [AW-1:0] win_nx;
    logic [AW-1:0] row_nx;
    logic          step_xfer;

    // take a step when the output slot is free or drains this cycle
    assign step_ready = ~addr_valid | addr_ready;
    assign step_xfer  = step_valid & step_ready;

    // final beat leaves
    assign last_done = addr_valid & addr_ready & addr_last;

    // ******************************************************************
    // address walk
    // ******************************************************************

    always_comb begin
        cur_nx = cur_addr;
        win_nx = win_base;
        row_nx = row_base;
        case (step.kind)
            conv_addr_pkg::STEP_START: begin
                cur_nx = '0;
                win_nx = '0;
                row_nx = '0;
            end
            conv_addr_pkg::STEP_PIXEL: begin
                cur_nx = cur_addr + AW'(1);
            end
            conv_addr_pkg::STEP_ROW: begin
                cur_nx = cur_addr + jump.row_jump;
            end
            conv_addr_pkg::STEP_CHANNEL: begin
                cur_nx = cur_addr + jump.chan_jump;
            end
            conv_addr_pkg::STEP_NEXT_COL: begin
                // slide the window right by stride
                win_nx = win_base + jump.col_step;
                cur_nx = win_nx;
            end
            conv_addr_pkg::STEP_NEXT_ROW: begin
                // back to column 0, stride rows down
                row_nx = row_base + jump.row_step;
                win_nx = row_nx;
                cur_nx = row_nx;
            end
            default: begin
                cur_nx = cur_addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (step_xfer) begin
            cur_addr <= cur_nx;
            win_base <= win_nx;
            row_base <= row_nx;
            addr     <= cur_nx + ADDR_BASE;
        end
    end

    // ******************************************************************
    // output slot
    // ******************************************************************

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_valid <= 1'b0;
            addr_last  <= 1'b0;
        end else if (step_xfer) begin
            addr_valid <= 1'b1;
            addr_last  <= step.last;
        end else if (addr_ready) begin
            addr_valid <= 1'b0;
            addr_last  <= 1'b0;
        end
    end

endmodule

// ==== src/apb_cfg_decode.sv ====
`timescale 1ns/10ps

module apb_cfg_decode (
    input  logic                    clk,
    input  logic                    rstn,
    input  conv_addr_pkg::apb_req_t apb_req,
    output conv_addr_pkg::apb_rsp_t apb_rsp,
    input  logic                    busy,
    input  logic                    last_done,
    output conv_addr_pkg::geom_t    geom,
    output conv_addr_pkg::jump_t    jump,
    output logic                    start
);

    localparam int AW = conv_addr_pkg::ADDR_W;

    conv_addr_pkg::cfg_word_u wdata;
    conv_addr_pkg::geom_t     geom_reg;
    conv_addr_pkg::jump_t     jump_nx;

    logic          access;
    logic          hit_geom;
    logic          hit_ctrl;
    logic          hit_status;
    logic          bad_addr;
    logic          run_active;
    logic          wr_reject;
    logic          geom_wr;
    logic          start_wr;
    logic          clear_wr;
    logic          done_sticky;
    logic [AW-1:0] t_ext;
    logic [AW-1:0] k_ext;
    logic [AW-1:0] s_ext;

    // ******************************************************************
    // apb access decode
    // ******************************************************************

    // access phase of a transfer
    assign access     = apb_req.psel & apb_req.penable;
    assign hit_geom   = (apb_req.paddr == conv_addr_pkg::REG_GEOM);
    assign hit_ctrl   = (apb_req.paddr == conv_addr_pkg::REG_CTRL);
    assign hit_status = (apb_req.paddr == conv_addr_pkg::REG_STATUS);
    assign bad_addr   = ~(hit_geom | hit_ctrl | hit_status);

    // same write word, two views
    assign wdata = apb_req.pwdata;

    // run in flight, includes the start pulse cycle
    assign run_active = busy | start;

    // geometry or start write during a run is refused
    assign wr_reject = apb_req.pwrite & run_active &
                       (hit_geom | (hit_ctrl & wdata.ctrl.start));

    assign geom_wr  = access & apb_req.pwrite & hit_geom & ~run_active;
    assign start_wr = access & apb_req.pwrite & hit_ctrl & wdata.ctrl.start & ~run_active;
    assign clear_wr = access & apb_req.pwrite & hit_ctrl & wdata.ctrl.clear_done;

    // no wait states
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & (bad_addr | wr_reject);

    // read mux
    always_comb begin
        apb_rsp.prdata = '0;
        if (hit_geom) begin
            apb_rsp.prdata = geom_reg;
        end else if (hit_status) begin
            apb_rsp.prdata = {30'd0, done_sticky, run_active};
        end
    end

    // ******************************************************************
    // jump constants
    // ******************************************************************

    assign t_ext = AW'(geom_reg.tensor_size);
    assign k_ext = AW'(geom_reg.kernel_size);
    assign s_ext = AW'(geom_reg.stride);

    always_comb begin
        // last kernel column to first column of next kernel row
        jump_nx.row_jump  = t_ext - k_ext + AW'(1);
        // bottom right of a kernel plane to top left of the next channel
        jump_nx.chan_jump = t_ext * t_ext - (k_ext - AW'(1)) * (t_ext + AW'(1));
        jump_nx.col_step  = s_ext;
        jump_nx.row_step  = s_ext * t_ext;
    end

    // ******************************************************************
    // registers
    // ******************************************************************

    // software geometry register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            geom_reg <= '0;
        end else if (geom_wr) begin
            geom_reg <= wdata.geom;
        end
    end

    // run copy, frozen until the next start
    always_ff @(posedge clk) begin
        if (start_wr) begin
            geom <= geom_reg;
            jump <= jump_nx;
        end
    end

    // one cycle start pulse after the access phase
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start <= 1'b0;
        end else begin
            start <= start_wr;
        end
    end

    // sticky done, a new start clears it too
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            done_sticky <= 1'b0;
        end else if (start_wr) begin
            done_sticky <= 1'b0;
        end else if (last_done) begin
            done_sticky <= 1'b1;
        end else if (clear_wr) begin
            done_sticky <= 1'b0;
        end
    end

endmodule

// ==== src/conv_addr_pkg.sv ====
package conv_addr_pkg;

    // ******************************************************************
    // field widths
    // ******************************************************************

    // tensor size, channels, out size
    localparam int DIM_W  = 8;
    // kernel size, stride
    localparam int KS_W   = 4;
    // feature-map address
    localparam int ADDR_W = 16;

    // apb register map
    localparam logic [7:0] REG_GEOM   = 8'h00;
    localparam logic [7:0] REG_CTRL   = 8'h04;
    localparam logic [7:0] REG_STATUS = 8'h08;

    // ******************************************************************
    // apb bus
    // ******************************************************************

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // ******************************************************************
    // configuration words
    // ******************************************************************

    // geometry word, tensor size in the top byte
    typedef struct packed {
        logic [DIM_W-1:0] tensor_size;
        logic [KS_W-1:0]  kernel_size;
        logic [KS_W-1:0]  stride;
        logic [DIM_W-1:0] channels;
        logic [DIM_W-1:0] out_size;
    } geom_t;

    // control word, start in bit 0 and clear_done in bit 1
    typedef struct packed {
        logic [29:0] reserved;
        logic        clear_done;
        logic        start;
    } ctrl_t;

    // one pwdata word, read as geometry or control by paddr
    typedef union packed {
        geom_t geom;
        ctrl_t ctrl;
    } cfg_word_u;

    // address jumps, fixed for a whole run
    typedef struct packed {
        logic [ADDR_W-1:0] row_jump;
        logic [ADDR_W-1:0] chan_jump;
        logic [ADDR_W-1:0] col_step;
        logic [ADDR_W-1:0] row_step;
    } jump_t;

    // how the next address is reached from the previous one
    typedef enum logic [2:0] {
        STEP_START,
        STEP_PIXEL,
        STEP_ROW,
        STEP_CHANNEL,
        STEP_NEXT_COL,
        STEP_NEXT_ROW
    } step_kind_e;

    typedef struct packed {
        step_kind_e kind;
        logic       last;
    } step_t;

endpackage

// ==== src/im2col_addr_top.sv ====
`timescale 1ns/10ps

module im2col_addr_top #(
    parameter logic [conv_addr_pkg::ADDR_W-1:0] ADDR_BASE = '0
) (
    input  logic                               clk,
    input  logic                               rstn,
    input  conv_addr_pkg::apb_req_t            apb_req,
    output conv_addr_pkg::apb_rsp_t            apb_rsp,
    output logic [conv_addr_pkg::ADDR_W-1:0]   addr,
    output logic                               addr_valid,
    output logic                               addr_last,
    input  logic                               addr_ready
);

    // decode to walker and accumulator
    conv_addr_pkg::geom_t geom;
    conv_addr_pkg::jump_t jump;
    logic                 start;

    // walker to accumulator
    conv_addr_pkg::step_t step;
    logic                 step_valid;
    logic                 step_ready;

    // status back to decode
    logic                 busy;
    logic                 last_done;

    // ******************************************************************
    // register file
    // ******************************************************************

    apb_cfg_decode u_apb_cfg_decode (
        .clk       (clk),
        .rstn      (rstn),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .busy      (busy),
        .last_done (last_done),
        .geom      (geom),
        .jump      (jump),
        .start     (start)
    );

    // ******************************************************************
    // walk and address stages
    // ******************************************************************

    window_walker u_window_walker (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .geom       (geom),
        .step       (step),
        .step_valid (step_valid),
        .step_ready (step_ready),
        .busy       (busy)
    );

    addr_accum #(
        .ADDR_BASE (ADDR_BASE)
    ) u_addr_accum (
        .clk        (clk),
        .rstn       (rstn),
        .step       (step),
        .step_valid (step_valid),
        .step_ready (step_ready),
        .jump       (jump),
        .addr       (addr),
        .addr_valid (addr_valid),
        .addr_last  (addr_last),
        .addr_ready (addr_ready),
        .last_done  (last_done)
    );

endmodule

// ==== src/window_walker.sv ====
`timescale 1ns/10ps

module window_walker (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  start,
    input  conv_addr_pkg::geom_t  geom,
    output conv_addr_pkg::step_t  step,
    output logic                  step_valid,
    input  logic                  step_ready,
    output logic                  busy
);

    localparam int KW = conv_addr_pkg::KS_W;
    localparam int DW = conv_addr_pkg::DIM_W;

    // position of the step held in the output
    logic [KW-1:0] kcol;
    logic [KW-1:0] krow;
    logic [DW-1:0] chan;
    logic [DW-1:0] ocol;
    logic [DW-1:0] orow;

    // position of the following step
    logic [KW-1:0] kcol_nx;
    logic [KW-1:0] krow_nx;
    logic [DW-1:0] chan_nx;
    logic [DW-1:0] ocol_nx;
    logic [DW-1:0] orow_nx;

    // final counter values
    logic [KW-1:0] k_fin;
    logic [DW-1:0] c_fin;
    logic [DW-1:0] o_fin;

    logic kcol_end;
    logic krow_end;
    logic chan_end;
    logic ocol_end;
    logic first_last;
    logic last_nx;
    logic step_xfer;

    conv_addr_pkg::step_kind_e kind_nx;

    assign k_fin = geom.kernel_size - KW'(1);
    assign c_fin = geom.channels - DW'(1);
    assign o_fin = geom.out_size - DW'(1);

    assign kcol_end = (kcol == k_fin);
    assign krow_end = (krow == k_fin);
    assign chan_end = (chan == c_fin);
    assign ocol_end = (ocol == o_fin);

    // 1x1 kernel, one channel, one output
    assign first_last = (k_fin == '0) & (c_fin == '0) & (o_fin == '0);

    assign step_xfer = step_valid & step_ready;

    // busy exactly while a step is held
    assign busy = step_valid;

    // ******************************************************************
    // next position and step kind
    // ******************************************************************

    // innermost is the kernel column, outermost the output row
    always_comb begin
        kind_nx = conv_addr_pkg::STEP_PIXEL;
        kcol_nx = kcol + KW'(1);
        krow_nx = krow;
        chan_nx = chan;
        ocol_nx = ocol;
        orow_nx = orow;
        if (kcol_end) begin
            kcol_nx = '0;
            if (!krow_end) begin
                // down one kernel row
                kind_nx = conv_addr_pkg::STEP_ROW;
                krow_nx = krow + KW'(1);
            end else begin
                krow_nx = '0;
                if (!chan_end) begin
                    // next channel plane
                    kind_nx = conv_addr_pkg::STEP_CHANNEL;
                    chan_nx = chan + DW'(1);
                end else begin
                    // window done
                    chan_nx = '0;
                    if (!ocol_end) begin
                        kind_nx = conv_addr_pkg::STEP_NEXT_COL;
                        ocol_nx = ocol + DW'(1);
                    end else begin
                        kind_nx = conv_addr_pkg::STEP_NEXT_ROW;
                        ocol_nx = '0;
                        orow_nx = orow + DW'(1);
                    end
                end
            end
        end
    end

    // every counter at its final value
    assign last_nx = (kcol_nx == k_fin) & (krow_nx == k_fin) & (chan_nx == c_fin) &
                     (ocol_nx == o_fin) & (orow_nx == o_fin);

    // ******************************************************************
    // counters and step register
    // ******************************************************************

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            kcol       <= '0;
            krow       <= '0;
            chan       <= '0;
            ocol       <= '0;
            orow       <= '0;
            step       <= '0;
            step_valid <= 1'b0;
        end else if (start && !step_valid) begin
            // fresh walk from the top left
            kcol       <= '0;
            krow       <= '0;
            chan       <= '0;
            ocol       <= '0;
            orow       <= '0;
            step.kind  <= conv_addr_pkg::STEP_START;
            step.last  <= first_last;
            step_valid <= 1'b1;
        end else if (step_xfer) begin
            if (step.last) begin
                step_valid <= 1'b0;
            end else begin
                kcol      <= kcol_nx;
                krow      <= krow_nx;
                chan      <= chan_nx;
                ocol      <= ocol_nx;
                orow      <= orow_nx;
                step.kind <= kind_nx;
                step.last <= last_nx;
            end
        end
    end

endmodule

// ==== verif/im2col_addr_props.sv ====
`timescale 1ns/10ps

module im2col_addr_props (
    input logic                             clk,
    input logic                             rstn,
    input logic                             start,
    input logic [conv_addr_pkg::ADDR_W-1:0] addr,
    input logic                             addr_valid,
    input logic                             addr_last,
    input logic                             addr_ready
);

    // set by the first start pulse after reset
    logic started;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
        end
    end

    // ******************************************************************
    // stream handshake
    // ******************************************************************

    // a stalled beat is never withdrawn
    a_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
        addr_valid && !addr_ready |=> addr_valid)
        else $error("addr_valid dropped before the beat was accepted");

    // payload frozen while stalled
    a_payload_stable: assert property (@(posedge clk) disable iff (!rstn)
        addr_valid && !addr_ready |=> $stable(addr) && $stable(addr_last))
        else $error("addr or addr_last changed while the beat was stalled");

    // nothing comes out before the first start
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
        !started |-> !addr_valid)
        else $error("addr_valid high before any start");

endmodule

bind im2col_addr_top im2col_addr_props u_im2col_addr_props (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .addr       (addr),
    .addr_valid (addr_valid),
    .addr_last  (addr_last),
    .addr_ready (addr_ready)
);

// ==== verif/im2col_addr_tb.sv ====
`timescale 1ns/10ps

module im2col_addr_tb;

    localparam logic [15:0] ADDR_BASE = 16'h0100;

    logic                    clk;
    logic                    rstn;
    conv_addr_pkg::apb_req_t apb_req;
    conv_addr_pkg::apb_rsp_t apb_rsp;
    logic [15:0]             addr;
    logic                    addr_valid;
    logic                    addr_last;
    logic                    addr_ready;

    // expected beats in walk order
    logic [15:0] exp_q[$];
    int          beat_count;

    im2col_addr_top #(
        .ADDR_BASE (ADDR_BASE)
    ) u_im2col_addr_top (
        .clk        (clk),
        .rstn       (rstn),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .addr       (addr),
        .addr_valid (addr_valid),
        .addr_last  (addr_last),
        .addr_ready (addr_ready)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random consumer stalls, ready about 3 cycles in 4
    always @(negedge clk) begin
        addr_ready = ($urandom_range(3) != 0);
    end

    // ******************************************************************
    // reference model and reporting
    // ******************************************************************

    // direct address of one tap: channel plane, tensor row, tensor column
    function automatic logic [15:0] expected_addr(input int orow, input int ocol, input int ch,
                                                  input int kr, input int kc, input int t,
                                                  input int s);
        int off;
        off = ch * t * t + (orow * s + kr) * t + ocol * s + kc;
        return ADDR_BASE + 16'(off);
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got == exp) else report_fail($sformatf("Fail %s expected %h got %h",
                                                       name, exp, got));
    endtask

    // every accepted beat against the head of the queue
    always @(posedge clk) begin : compare_beats
        logic [15:0] exp_a;
        logic        exp_last;
        if (rstn && addr_valid && addr_ready) begin
            if (exp_q.size() == 0) begin
                report_fail("an address beat arrived when none was expected");
            end else begin
                exp_a    = exp_q.pop_front();
                exp_last = (exp_q.size() == 0);
                beat_count++;
                assert (addr == exp_a) else report_fail(
                    $sformatf("Fail addr expected %h got %h", exp_a, addr));
                assert (addr_last == exp_last) else report_fail(
                    $sformatf("Fail addr_last expected %h got %h", exp_last, addr_last));
            end
        end
    end

    // ******************************************************************
    // apb master
    // ******************************************************************

    // setup and access on falling edges, response sampled mid access cycle
    task automatic apb_xfer(input logic wr, input logic [7:0] a, input logic [31:0] wd,
                            output logic [31:0] rd, output logic err);
        int waited;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = a;
        apb_req.pwdata  = wd;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        waited = 0;
        while (!apb_rsp.pready) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > 16) begin
                report_fail("timeout waiting for pready");
            end
        end
        rd  = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] a, input logic [31:0] wd, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, a, wd, rd, err);
        check_value("pslverr", 32'(exp_err), 32'(err));
    endtask

    task automatic apb_read(input logic [7:0] a, input logic [31:0] exp_data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, a, 32'd0, rd, err);
        check_value("pslverr", 32'd0, 32'(err));
        check_value("prdata", exp_data, rd);
    endtask

    // ******************************************************************
    // one convolution run
    // ******************************************************************

    task automatic run_geometry(input int t, input int k, input int s, input int c,
                                input int o, input bit check_run);
        conv_addr_pkg::geom_t g;
        conv_addr_pkg::ctrl_t cw;
        int total;
        int waited;
        g.tensor_size = 8'(t);
        g.kernel_size = 4'(k);
        g.stride      = 4'(s);
        g.channels    = 8'(c);
        g.out_size    = 8'(o);
        total         = o * o * c * k * k;
        beat_count    = 0;
        // output row outermost, kernel column innermost
        for (int orow = 0; orow < o; orow++) begin
            for (int ocol = 0; ocol < o; ocol++) begin
                for (int ch = 0; ch < c; ch++) begin
                    for (int kr = 0; kr < k; kr++) begin
                        for (int kc = 0; kc < k; kc++) begin
                            exp_q.push_back(expected_addr(orow, ocol, ch, kr, kc, t, s));
                        end
                    end
                end
            end
        end
        apb_write(conv_addr_pkg::REG_GEOM, g, 1'b0);
        cw       = '0;
        cw.start = 1'b1;
        apb_write(conv_addr_pkg::REG_CTRL, cw, 1'b0);
        if (check_run) begin
            // busy and locked geometry mid run
            apb_read(conv_addr_pkg::REG_STATUS, 32'h1);
            apb_write(conv_addr_pkg::REG_GEOM, 32'h0911_0101, 1'b1);
        end
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 20 * total + 100) begin
                report_fail($sformatf("timeout waiting for beat %0d of %0d",
                                      beat_count + 1, total));
            end
        end
        if (check_run) begin
            apb_read(conv_addr_pkg::REG_GEOM, g);
        end
        // done set, busy gone
        apb_read(conv_addr_pkg::REG_STATUS, 32'h2);
        cw            = '0;
        cw.clear_done = 1'b1;
        apb_write(conv_addr_pkg::REG_CTRL, cw, 1'b0);
        apb_read(conv_addr_pkg::REG_STATUS, 32'h0);
    endtask

    // ******************************************************************
    // test sequence
    // ******************************************************************

    initial begin : stimulus
        void'($urandom(44795));
        beat_count = 0;
        rstn       = 1'b0;
        apb_req    = '0;
        addr_ready = 1'b0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;

        // quiet after reset
        check_value("addr_valid", 32'd0, 32'(addr_valid));
        check_value("addr_last", 32'd0, 32'(addr_last));
        apb_read(conv_addr_pkg::REG_STATUS, 32'h0);

        // register readback and bad offset
        apb_write(conv_addr_pkg::REG_GEOM, 32'h5A3C_1207, 1'b0);
        apb_read(conv_addr_pkg::REG_GEOM, 32'h5A3C_1207);
        apb_write(8'h0C, 32'hFFFF_FFFF, 1'b1);

        // tensor, kernel, stride, channels, out size
        run_geometry(5, 3, 1, 2, 3, 1'b1);
        run_geometry(4, 1, 1, 1, 4, 1'b0);
        run_geometry(7, 3, 2, 3, 3, 1'b0);
        run_geometry(6, 2, 2, 1, 3, 1'b0);
        run_geometry(3, 1, 2, 3, 2, 1'b0);
        run_geometry(1, 1, 1, 1, 1, 1'b0);

        $display("** PASS **");
        $finish;
    end

endmodule
